/* Makefile */
# Verilator simulation of the predecode stage and instruction queue.

TOP       ?= tb_fetch_predecode
LOG       ?= sim.log
BUILD     ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
src/predecode_pkg.sv
src/pre_decoder.sv
src/predecode_stage.sv
src/inst_queue.sv
src/fetch_predecode_top.sv
dv/fetch_predecode_properties.sv
dv/tb_fetch_predecode.sv

/* dv/fetch_predecode_properties.sv */
`timescale 1ns/1ps

module fetch_predecode_properties #(
    parameter int BLOCK_INSTS = 4
) (
    input logic                               clk,
    input logic                               rst,
    input logic                               flush,
    input logic                               redirect_valid,
    input logic                               out_valid,
    input logic                               out_ready,
    input logic [31:0]                        out_inst,
    input logic [31:0]                        out_pc,
    input logic                               push_valid,
    input logic [$clog2(BLOCK_INSTS+1)-1:0]   push_count,
    input logic [$clog2(2*BLOCK_INSTS+1)-1:0] free_count
);

    // a redirect discards the block behind it, so two in a row cannot happen.
    a_redirect_single: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !redirect_valid)
        else $error("redirect_valid was high in two consecutive cycles");

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready && !flush) |=> ($stable(out_inst) && $stable(out_pc)))
        else $error("queue output changed while it was stalled");

    a_reset_quiet: assert property (@(posedge clk)
        rst |-> (!out_valid && !redirect_valid))
        else $error("output valid during reset");

    // accepting only with two blocks of room means the held block always fits.
    a_push_room: assert property (@(posedge clk) disable iff (rst)
        push_valid |-> (int'(free_count) >= int'(push_count)))
        else $error("stage pushed a block that does not fit in the queue");

endmodule

bind fetch_predecode_top fetch_predecode_properties #(
    .BLOCK_INSTS (BLOCK_INSTS)
) u_properties (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .redirect_valid (redirect_valid),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_inst       (out_inst),
    .out_pc         (out_pc),
    .push_valid     (push_valid),
    .push_count     (push_count),
    .free_count     (free_count)
);

/* dv/tb_fetch_predecode.sv */
`timescale 1ns/1ps

module tb_fetch_predecode;
    import predecode_pkg::*;

    localparam int BLOCK_INSTS = 4;
    localparam int QUEUE_DEPTH = 16;
    localparam int IDX_W       = $clog2(BLOCK_INSTS);
    localparam int NUM_BLOCKS  = 300;
    localparam int MAX_CYCLES  = 40 * NUM_BLOCKS + 200;

    logic                         clk;
    logic                         rst;
    logic                         flush;
    logic                         in_valid;
    logic                         in_ready;
    logic [VADDR_W-1:0]           in_start_addr;
    logic [IDX_W-1:0]             in_size;
    logic                         in_taken;
    br_type_e                     in_br_type;
    logic [VADDR_W-1:0]           in_target;
    logic [FSQ_W-1:0]             in_fsq_idx;
    logic [BLOCK_INSTS-1:0][31:0] in_data;
    logic                         redirect_valid;
    logic [FSQ_W-1:0]             redirect_fsq_idx;
    logic [VADDR_W-1:0]           redirect_target;
    logic [IDX_W-1:0]             redirect_size;
    logic                         redirect_taken;
    ras_type_e                    redirect_ras;
    logic                         out_valid;
    logic                         out_ready;
    logic [31:0]                  out_inst;
    logic [VADDR_W-1:0]           out_pc;

    logic [31:0]                  lfsr_state;
    int                           stall_left;
    int                           accepted_count;
    int                           mismatch_count;
    int                           other_count;

    // model copy of the block held in the stage.
    logic                         held_valid;
    logic [VADDR_W-1:0]           h_start;
    logic [IDX_W-1:0]             h_size;
    logic                         h_taken;
    br_type_e                     h_br;
    logic [VADDR_W-1:0]           h_target;
    logic [FSQ_W-1:0]             h_fsq;
    logic [BLOCK_INSTS-1:0][31:0] h_data;
    logic [63:0]                  exp_q[$];

    fetch_predecode_top #(
        .BLOCK_INSTS (BLOCK_INSTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_start_addr    (in_start_addr),
        .in_size          (in_size),
        .in_taken         (in_taken),
        .in_br_type       (in_br_type),
        .in_target        (in_target),
        .in_fsq_idx       (in_fsq_idx),
        .in_data          (in_data),
        .redirect_valid   (redirect_valid),
        .redirect_fsq_idx (redirect_fsq_idx),
        .redirect_target  (redirect_target),
        .redirect_size    (redirect_size),
        .redirect_taken   (redirect_taken),
        .redirect_ras     (redirect_ras),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_inst         (out_inst),
        .out_pc           (out_pc)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // link registers x1 and x5 come up often so the RAS hints get exercised.
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = rand_bits(2);
        case (r[1:0])
            2'd0: return 5'd1;
            2'd1: return 5'd5;
            default: begin
                r = rand_bits(5);
                return r[4:0];
            end
        endcase
    endfunction

    function automatic logic is_jal_inst(input logic [31:0] i);
        return i[6:0] == 7'b1101111;
    endfunction

    function automatic logic is_ctrl_inst(input logic [31:0] i);
        return (i[6:0] == 7'b1101111) || (i[6:0] == 7'b1100111) || (i[6:0] == 7'b1100011);
    endfunction

    // bits 31:12 of a jal hold imm[20|10:1|11|19:12], with imm[20] as the sign.
    function automatic logic [31:0] jal_target(input logic [31:0] i, input logic [31:0] pc);
        int offset;
        offset = int'(i[30:21]) * 2 + int'(i[20]) * 2048 + int'(i[19:12]) * 4096;
        if (i[31]) begin
            offset = offset - (1 << 20);
        end
        return pc + 32'(offset);
    endfunction

    function automatic ras_type_e jal_ras(input logic [31:0] i);
        return (i[11:7] == 5'd1 || i[11:7] == 5'd5) ? PUSH : NONE;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        mismatch_count++;
        $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic tick();
        logic [31:0] r;
        @(negedge clk);
        flush = 1'b0;
        r = rand_bits(2);
        out_ready = (stall_left > 0) ? 1'b0 : (r[1:0] != 2'd0);
        if (stall_left > 0) begin
            stall_left--;
        end
    endtask

    task automatic make_block(input int b);
        logic [31:0]                  r;
        logic [31:0]                  hi;
        logic [4:0]                   rd;
        logic [4:0]                   rs1;
        int                           first;
        logic [IDX_W-1:0]             size;
        logic [VADDR_W-1:0]           start;
        logic [BLOCK_INSTS-1:0][31:0] data;
        r = rand_bits(30);
        start = {r[29:0], 2'b00};
        r = rand_bits(IDX_W);
        size = r[IDX_W-1:0];
        for (int i = 0; i < BLOCK_INSTS; i++) begin
            r = rand_bits(3);
            rd = pick_reg();
            rs1 = pick_reg();
            hi = rand_bits(20);
            case (r[2:0])
                3'd5: data[i] = {hi[19:0], rd, 7'b1100011};
                3'd6: data[i] = {hi[11:0], rs1, 3'b000, rd, 7'b1100111};
                3'd7: data[i] = {hi[19:0], rd, 7'b1101111};
                default: data[i] = {hi[11:0], rs1, 3'b000, rd, 7'b0010011};
            endcase
        end
        first = -1;
        for (int i = 0; i < BLOCK_INSTS; i++) begin
            if (first < 0 && i <= int'(size) && is_jal_inst(data[i])) begin
                first = i;
            end
        end
        r = rand_bits(2);
        in_target = rand_bits(32);
        if (r[1:0] != 2'd0) begin
            // a correct prediction ends the block at its first jal.
            in_taken = 1'b0;
            in_br_type = CONDITION;
            if (first >= 0) begin
                size = IDX_W'(first);
                in_taken = 1'b1;
                in_br_type = DIRECT;
                in_target = jal_target(data[first], start + VADDR_W'(4 * first));
            end else if (is_ctrl_inst(data[size])) begin
                r = rand_bits(1);
                in_taken = r[0];
            end
        end else begin
            r = rand_bits(3);
            in_taken = r[0];
            in_br_type = r[1] ? DIRECT : CONDITION;
            if (r[2] && first >= 0) begin
                in_target = jal_target(data[first], start + VADDR_W'(4 * first));
            end
        end
        in_start_addr = start;
        in_size = size;
        in_fsq_idx = FSQ_W'(b);
        in_data = data;
    endtask

    always @(posedge clk or posedge rst) begin
        logic [63:0]        e;
        int                 first;
        int                 kept;
        logic               rule_a;
        logic               rule_b;
        logic               exp_redir;
        logic               exp_ready;
        logic [VADDR_W-1:0] exp_tgt;
        ras_type_e          exp_ras;
        if (rst) begin
            held_valid = 1'b0;
            exp_q.delete();
        end else begin
            // the model queue holds exactly what the DUT queue holds before this edge.
            exp_ready = (QUEUE_DEPTH - exp_q.size()) >= 2 * BLOCK_INSTS;
            assert (in_ready == exp_ready)
                else report_mismatch("in_ready", 32'(exp_ready), 32'(in_ready));
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("unexpected instruction %h at pc %h delivered at %0t ns",
                             out_inst, out_pc, $time);
                end else begin
                    e = exp_q.pop_front();
                    assert (out_inst == e[63:32])
                        else report_mismatch("out_inst", e[63:32], out_inst);
                    assert (out_pc == e[31:0])
                        else report_mismatch("out_pc", e[31:0], out_pc);
                end
            end
            exp_redir = 1'b0;
            kept = 0;
            if (held_valid) begin
                first = -1;
                for (int i = 0; i < BLOCK_INSTS; i++) begin
                    if (first < 0 && i <= int'(h_size) && is_jal_inst(h_data[i])) begin
                        first = i;
                    end
                end
                rule_a = 1'b0;
                if (first >= 0) begin
                    exp_tgt = jal_target(h_data[first], h_start + VADDR_W'(4 * first));
                    exp_ras = jal_ras(h_data[first]);
                    rule_a = !h_taken || int'(h_size) != first || h_br != DIRECT ||
                             h_target != exp_tgt;
                end
                rule_b = h_taken && !is_ctrl_inst(h_data[h_size]) && !rule_a;
                if (rule_b) begin
                    exp_tgt = h_start + VADDR_W'(4 * (int'(h_size) + 1));
                    exp_ras = NONE;
                end
                exp_redir = rule_a || rule_b;
                kept = rule_a ? first : int'(h_size);
            end
            assert (redirect_valid == exp_redir) else begin
                other_count++;
                if (exp_redir) begin
                    $display("missing redirect at %0t ns for block fsq %0d", $time, h_fsq);
                end else begin
                    $display("extra redirect at %0t ns with no mispredicted block", $time);
                end
            end
            if (redirect_valid && exp_redir) begin
                assert (redirect_fsq_idx == h_fsq)
                    else report_mismatch("redirect_fsq_idx", 32'(h_fsq), 32'(redirect_fsq_idx));
                assert (redirect_target == exp_tgt)
                    else report_mismatch("redirect_target", exp_tgt, redirect_target);
                assert (int'(redirect_size) == kept)
                    else report_mismatch("redirect_size", 32'(kept), 32'(redirect_size));
                assert (redirect_taken == rule_a)
                    else report_mismatch("redirect_taken", 32'(rule_a), 32'(redirect_taken));
                assert (redirect_ras == exp_ras)
                    else report_mismatch("redirect_ras", 32'(exp_ras), 32'(redirect_ras));
            end
            if (held_valid && !flush) begin
                for (int i = 0; i <= kept; i++) begin
                    exp_q.push_back({h_data[i], h_start + VADDR_W'(4 * i)});
                end
            end
            if (flush) begin
                exp_q.delete();
            end
            if (in_valid && in_ready) begin
                accepted_count++;
            end
            held_valid = in_valid && in_ready && !flush && !exp_redir;
            h_start = in_start_addr;
            h_size = in_size;
            h_taken = in_taken;
            h_br = in_br_type;
            h_target = in_target;
            h_fsq = in_fsq_idx;
            h_data = in_data;
        end
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int want;
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        in_start_addr = '0;
        in_size = '0;
        in_taken = 1'b0;
        in_br_type = CONDITION;
        in_target = '0;
        in_fsq_idx = '0;
        in_data = '0;
        out_ready = 1'b0;
        stall_left = 0;
        lfsr_state = 32'h179f_b85b;
        accepted_count = 0;
        mismatch_count = 0;
        other_count = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            if (b == 100 || b == 220) begin
                in_valid = 1'b0;
                flush = 1'b1;
                out_ready = 1'b0;
                tick();
            end
            // a long stall fills the queue and pulls in_ready low.
            if (b == 140 || b == 180) begin
                stall_left = 40;
            end
            make_block(b);
            in_valid = 1'b1;
            want = accepted_count + 1;
            do begin
                tick();
            end while (accepted_count < want);
        end
        in_valid = 1'b0;
        stall_left = 0;
        while (exp_q.size() != 0 || held_valid) begin
            tick();
        end
        repeat (5) tick();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* src/fetch_predecode_top.sv */
`timescale 1ns/1ps

module fetch_predecode_top
    import predecode_pkg::*;
#(
    parameter int BLOCK_INSTS = 4,
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flush,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [VADDR_W-1:0]               in_start_addr,
    input  logic [$clog2(BLOCK_INSTS)-1:0]   in_size,
    input  logic                             in_taken,
    input  br_type_e                         in_br_type,
    input  logic [VADDR_W-1:0]               in_target,
    input  logic [FSQ_W-1:0]                 in_fsq_idx,
    input  logic [BLOCK_INSTS-1:0][31:0]     in_data,
    output logic                             redirect_valid,
    output logic [FSQ_W-1:0]                 redirect_fsq_idx,
    output logic [VADDR_W-1:0]               redirect_target,
    output logic [$clog2(BLOCK_INSTS)-1:0]   redirect_size,
    output logic                             redirect_taken,
    output ras_type_e                        redirect_ras,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [31:0]                      out_inst,
    output logic [VADDR_W-1:0]               out_pc
);

    logic                                 push_valid;
    logic [$clog2(BLOCK_INSTS+1)-1:0]     push_count;
    logic [BLOCK_INSTS-1:0][31:0]         push_inst;
    logic [VADDR_W-1:0]                   push_pc_base;
    logic [$clog2(2*BLOCK_INSTS+1)-1:0]   free_count;

    predecode_stage #(
        .BLOCK_INSTS (BLOCK_INSTS)
    ) u_stage (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_start_addr    (in_start_addr),
        .in_size          (in_size),
        .in_taken         (in_taken),
        .in_br_type       (in_br_type),
        .in_target        (in_target),
        .in_fsq_idx       (in_fsq_idx),
        .in_data          (in_data),
        .free_count       (free_count),
        .redirect_valid   (redirect_valid),
        .redirect_fsq_idx (redirect_fsq_idx),
        .redirect_target  (redirect_target),
        .redirect_size    (redirect_size),
        .redirect_taken   (redirect_taken),
        .redirect_ras     (redirect_ras),
        .push_valid       (push_valid),
        .push_count       (push_count),
        .push_inst        (push_inst),
        .push_pc_base     (push_pc_base)
    );

    inst_queue #(
        .BLOCK_INSTS (BLOCK_INSTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .push_valid   (push_valid),
        .push_count   (push_count),
        .push_inst    (push_inst),
        .push_pc_base (push_pc_base),
        .free_count   (free_count),
        .out_valid    (out_valid),
        .out_inst     (out_inst),
        .out_pc       (out_pc),
        .out_ready    (out_ready)
    );

endmodule

/* src/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue
    import predecode_pkg::*;
#(
    parameter int BLOCK_INSTS = 4,
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 flush,
    input  logic                                 push_valid,
    input  logic [$clog2(BLOCK_INSTS+1)-1:0]     push_count,
    input  logic [BLOCK_INSTS-1:0][31:0]         push_inst,
    input  logic [VADDR_W-1:0]                   push_pc_base,
    output logic [$clog2(2*BLOCK_INSTS+1)-1:0]   free_count,
    output logic                                 out_valid,
    output logic [31:0]                          out_inst,
    output logic [VADDR_W-1:0]                   out_pc,
    input  logic                                 out_ready
);

    localparam int PTR_W  = $clog2(QUEUE_DEPTH);
    localparam int CNT_W  = $clog2(QUEUE_DEPTH+1);
    localparam int PUSH_W = $clog2(BLOCK_INSTS+1);
    localparam int FREE_W = $clog2(2*BLOCK_INSTS+1);

    logic [31:0]        mem_inst [QUEUE_DEPTH];
    logic [VADDR_W-1:0] mem_pc   [QUEUE_DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   free_slots;
    logic [CNT_W-1:0]   push_amt;
    logic               pop;

    assign out_valid = (count != '0);
    assign out_inst  = mem_inst[head];
    assign out_pc    = mem_pc[head];
    assign pop       = out_valid && out_ready;
    assign push_amt  = push_valid ? CNT_W'(push_count) : '0;

    // the stage only needs to know whether two blocks fit, so the value saturates there.
    assign free_slots = CNT_W'(QUEUE_DEPTH) - count;
    assign free_count = (free_slots >= CNT_W'(2 * BLOCK_INSTS)) ?
                        FREE_W'(2 * BLOCK_INSTS) : FREE_W'(free_slots);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_valid) begin
                tail <= tail + PTR_W'(push_count);
            end
            if (pop) begin
                head <= head + PTR_W'(1);
            end
            count <= count + push_amt - CNT_W'(pop);
        end
    end

    // entries land at consecutive slots, wrapping with the pointer width.
    always_ff @(posedge clk) begin
        if (push_valid && !flush) begin
            for (int i = 0; i < BLOCK_INSTS; i++) begin
                if (PUSH_W'(i) < push_count) begin
                    mem_inst[tail + PTR_W'(i)] <= push_inst[i];
                    mem_pc[tail + PTR_W'(i)]   <= push_pc_base + VADDR_W'(4 * i);
                end
            end
        end
    end

endmodule

/* src/pre_decoder.sv */
`timescale 1ns/1ps

module pre_decoder
    import predecode_pkg::*;
(
    input  logic [31:0]        inst,
    input  logic [VADDR_W-1:0] pc,
    output pd_info_t           info
);

    logic [6:0]         opcode;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic               is_jal;
    logic               is_jalr;
    logic               is_cond;
    logic               link_rd;
    logic               link_rs1;
    logic [VADDR_W-1:0] j_offset;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];

    assign is_jal  = (opcode == 7'b1101111);
    assign is_jalr = (opcode == 7'b1100111);
    assign is_cond = (opcode == 7'b1100011);

    // x1 and x5 are the link registers by the calling convention.
    assign link_rd  = (rd == 5'd1) || (rd == 5'd5);
    assign link_rs1 = (rs1 == 5'd1) || (rs1 == 5'd5);

    // the J-immediate is scattered over the upper bits and is always even.
    assign j_offset = {{(VADDR_W-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        info.is_branch = is_jal || is_jalr || is_cond;
        info.is_direct = is_jal;
        info.target    = pc + j_offset;
        if (is_jal) begin
            info.br_type  = DIRECT;
            info.ras_type = link_rd ? PUSH : NONE;
        end else if (is_jalr) begin
            info.br_type  = INDIRECT;
            info.ras_type = ras_type_e'({link_rs1, link_rd});
        end else begin
            info.br_type  = CONDITION;
            info.ras_type = NONE;
        end
    end

endmodule

/* src/predecode_pkg.sv */
package predecode_pkg;

    localparam int VADDR_W = 32;
    localparam int FSQ_W = 4;

    // branch class of a block prediction or of one decoded lane.
    typedef enum logic [1:0] {
        CONDITION = 2'd0,
        DIRECT    = 2'd1,
        INDIRECT  = 2'd2
    } br_type_e;

    // return-address-stack hint for a jump.
    typedef enum logic [1:0] {
        NONE     = 2'd0,
        PUSH     = 2'd1,
        POP      = 2'd2,
        POP_PUSH = 2'd3
    } ras_type_e;

    // result of predecoding one lane, 38 bits wide.
    typedef struct packed {
        logic               is_branch;
        logic               is_direct;
        br_type_e           br_type;
        ras_type_e          ras_type;
        logic [VADDR_W-1:0] target;
    } pd_info_t;

endpackage

/* src/predecode_stage.sv */
`timescale 1ns/1ps

module predecode_stage
    import predecode_pkg::*;
#(
    parameter int BLOCK_INSTS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 flush,
    input  logic                                 in_valid,
    output logic                                 in_ready,
    input  logic [VADDR_W-1:0]                   in_start_addr,
    input  logic [$clog2(BLOCK_INSTS)-1:0]       in_size,
    input  logic                                 in_taken,
    input  br_type_e                             in_br_type,
    input  logic [VADDR_W-1:0]                   in_target,
    input  logic [FSQ_W-1:0]                     in_fsq_idx,
    input  logic [BLOCK_INSTS-1:0][31:0]         in_data,
    input  logic [$clog2(2*BLOCK_INSTS+1)-1:0]   free_count,
    output logic                                 redirect_valid,
    output logic [FSQ_W-1:0]                     redirect_fsq_idx,
    output logic [VADDR_W-1:0]                   redirect_target,
    output logic [$clog2(BLOCK_INSTS)-1:0]       redirect_size,
    output logic                                 redirect_taken,
    output ras_type_e                            redirect_ras,
    output logic                                 push_valid,
    output logic [$clog2(BLOCK_INSTS+1)-1:0]     push_count,
    output logic [BLOCK_INSTS-1:0][31:0]         push_inst,
    output logic [VADDR_W-1:0]                   push_pc_base
);

    localparam int IDX_W  = $clog2(BLOCK_INSTS);
    localparam int PUSH_W = $clog2(BLOCK_INSTS+1);
    localparam int FREE_W = $clog2(2*BLOCK_INSTS+1);

    pd_info_t [BLOCK_INSTS-1:0] lane_info;
    logic                       accept;

    logic                       valid_q;
    pd_info_t [BLOCK_INSTS-1:0] info_q;
    logic [BLOCK_INSTS-1:0][31:0] data_q;
    logic [VADDR_W-1:0]         start_addr_q;
    logic [IDX_W-1:0]           size_q;
    logic                       taken_q;
    br_type_e                   br_type_q;
    logic [VADDR_W-1:0]         target_q;
    logic [FSQ_W-1:0]           fsq_idx_q;
    logic [VADDR_W-1:0]         fall_q;

    logic [BLOCK_INSTS-1:0]     lane_valid;
    logic [BLOCK_INSTS-1:0]     jump_hit;
    logic [IDX_W-1:0]           first_idx;
    pd_info_t                   jal_info;
    pd_info_t                   tail_info;
    logic                       rule_a;
    logic                       rule_b;
    logic [IDX_W-1:0]           kept_last;

    // decode the incoming block so that only a lookup is left for the check cycle.
    for (genvar i = 0; i < BLOCK_INSTS; i++) begin : g_lane
        pre_decoder u_pre_decoder (
            .inst (in_data[i]),
            .pc   (in_start_addr + VADDR_W'(4 * i)),
            .info (lane_info[i])
        );
    end

    // two blocks of room means the block in the stage can always be pushed.
    assign in_ready = (free_count >= FREE_W'(2 * BLOCK_INSTS));
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept && !flush && !redirect_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            info_q       <= lane_info;
            data_q       <= in_data;
            start_addr_q <= in_start_addr;
            size_q       <= in_size;
            taken_q      <= in_taken;
            br_type_q    <= in_br_type;
            target_q     <= in_target;
            fsq_idx_q    <= in_fsq_idx;
            fall_q       <= in_start_addr + ((VADDR_W'(in_size) + VADDR_W'(1)) << 2);
        end
    end

    always_comb begin
        for (int i = 0; i < BLOCK_INSTS; i++) begin
            lane_valid[i] = (IDX_W'(i) <= size_q);
            jump_hit[i]   = lane_valid[i] && info_q[i].is_direct;
        end
    end

    // walking down from the top leaves the lowest jal selected.
    always_comb begin
        first_idx = '0;
        for (int i = BLOCK_INSTS - 1; i >= 0; i--) begin
            if (jump_hit[i]) begin
                first_idx = IDX_W'(i);
            end
        end
    end

    assign jal_info  = info_q[first_idx];
    assign tail_info = info_q[size_q];

    assign rule_a = (|jump_hit) &&
                    (!taken_q || (size_q != first_idx) || (br_type_q != DIRECT) ||
                     (target_q != jal_info.target));
    assign rule_b = taken_q && !tail_info.is_branch && !rule_a;

    assign redirect_valid   = valid_q && (rule_a || rule_b);
    assign redirect_fsq_idx = fsq_idx_q;
    assign redirect_target  = rule_a ? jal_info.target : fall_q;
    assign redirect_size    = rule_a ? first_idx : size_q;
    assign redirect_taken   = rule_a;
    assign redirect_ras     = rule_a ? jal_info.ras_type : NONE;

    // a missed jal cuts the block short; everything else keeps all valid lanes.
    assign kept_last    = rule_a ? first_idx : size_q;
    assign push_valid   = valid_q;
    assign push_count   = PUSH_W'(kept_last) + PUSH_W'(1);
    assign push_inst    = data_q;
    assign push_pc_base = start_addr_q;

endmodule
